// ==== rtl/c64_loader_settings.svh ====
`ifndef C64_LOADER_SETTINGS_SVH
`define C64_LOADER_SETTINGS_SVH

// ============================================================
// Widths and file indices
// ============================================================
`define SDRAM_ADDR_W       25
`define PRG_INDEX          8'd4
`define CRT_INDEX          8'd5

// ============================================================
// Memory layout and CRT file offsets
// ============================================================
`define CRT_BASE           25'h100000  // First cartridge data byte
`define CRT_ALIGN_BITS     13          // 8 KB bank alignment
`define CRT_ID_OFS         'h16        // Cartridge id, big endian
`define CRT_EXROM_OFS      'h18
`define CRT_GAME_OFS       'h19
`define CRT_CHIP_OFS       'h40        // First chip packet
`define CRT_CHIP_HDR_LEN   16
`define MEMINIT_END        'h100       // Zero page size

`endif

// ==== rtl/c64_loader_pkg.sv ====
`default_nettype none

package c64_loader_pkg;

`include "c64_loader_settings.svh"

	// Plain vectors with a meaning
	typedef logic [7:0]                 byte_t;
	typedef logic [`SDRAM_ADDR_W-1:0]   sdram_addr_t;
	typedef logic [15:0]                c64_addr_t;
	typedef logic [7:0]                 file_index_t;
	typedef logic [31:0]                crt_len_t;

	// Loader sequence
	typedef enum logic [1:0] {
		IDLE,
		DOWNLOAD,
		MEMINIT,      // Zero page pointer patch after a PRG
		FINISH
	} load_state_t;

	// Position inside a CRT file
	typedef enum logic [1:0] {
		FILE_HDR,
		CHIP_HDR,
		CHIP_DATA
	} crt_state_t;

endpackage

`default_nettype wire

// ==== rtl/load_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "c64_loader_settings.svh"

module load_ctrl import c64_loader_pkg::*; (
	input  wire         clk_sys,
	input  wire         reset_n,
	input  wire         dl_active_i,
	input  file_index_t dl_index_i,
	input  byte_t       dl_data_i,
	input  wire         dl_valid_i,
	input  wire         prg_data_i,
	input  c64_addr_t   prg_start_i,
	input  wire         start_valid_i,
	input  wire         crt_data_i,
	input  wire         crt_align_i,
	input  c64_addr_t   prg_end_i,
	input  wire         patch_i,
	input  byte_t       patch_val_i,
	input  wire         wr_busy_i,
	output logic        dl_ready_o,
	output logic        accept_o,
	output logic        is_prg_o,
	output logic        is_crt_o,
	output sdram_addr_t load_addr_o,
	output logic        wr_req_o,
	output byte_t       wr_data_o,
	output logic        cart_attached_o,
	output logic        inject_done_o,
	output logic        meminit_o,
	output byte_t       init_addr_o
);

	localparam sdram_addr_t ALIGN_MASK = sdram_addr_t'((1 << `CRT_ALIGN_BITS) - 1);

	load_state_t state;
	file_index_t index_q;      // Kind of the file being loaded
	sdram_addr_t load_addr;
	byte_t       data_q;
	logic        meminit_last;
	logic        data_flag;

	assign data_flag    = prg_data_i | crt_data_i;
	assign meminit_last = (load_addr == sdram_addr_t'(`MEMINIT_END));

	// One write in flight, so hold the host off until the flag and the slot are clear
	assign dl_ready_o = (state == DOWNLOAD) && dl_active_i && !wr_busy_i && !data_flag;
	assign accept_o   = dl_valid_i && dl_ready_o;

	assign is_prg_o      = (state == DOWNLOAD) && (index_q == `PRG_INDEX);
	assign is_crt_o      = (state == DOWNLOAD) && (index_q == `CRT_INDEX);
	assign meminit_o     = (state == MEMINIT);
	assign inject_done_o = (state == FINISH);
	assign load_addr_o   = load_addr;
	assign init_addr_o   = load_addr[7:0];
	assign wr_data_o     = (state == MEMINIT) ? patch_val_i : data_q;

	always_comb begin
		wr_req_o = 1'b0;
		case (state)
			DOWNLOAD: wr_req_o = data_flag;
			MEMINIT:  wr_req_o = !wr_busy_i && !meminit_last && patch_i;
			default:  wr_req_o = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (accept_o)
			data_q <= dl_data_i;
	end

	// ============================================================
	// Sequence and load address
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state           <= IDLE;
			index_q         <= '0;
			load_addr       <= '0;
			cart_attached_o <= 1'b0;
		end else begin
			case (state)
				IDLE: if (dl_active_i) begin
					state   <= DOWNLOAD;
					index_q <= dl_index_i;
					if (dl_index_i == `CRT_INDEX) begin
						load_addr       <= `CRT_BASE;
						cart_attached_o <= 1'b0;    // New image replaces the old one
					end
				end
				DOWNLOAD: begin
					if (wr_req_o)
						load_addr <= load_addr + 1'b1;
					else if (start_valid_i)
						load_addr <= sdram_addr_t'(prg_start_i);
					else if (crt_align_i && ((load_addr & ALIGN_MASK) != '0))
						load_addr <= (load_addr | ALIGN_MASK) + 1'b1;   // Next 8 KB bank

					if (!dl_active_i) begin
						if (index_q == `PRG_INDEX) begin
							state     <= MEMINIT;
							load_addr <= '0;              // Walk the zero page
						end else begin
							state <= IDLE;
							if (index_q == `CRT_INDEX)
								cart_attached_o <= 1'b1;
						end
					end
				end
				MEMINIT: if (!wr_busy_i) begin
					// A patched address leaves with its write request
					if (meminit_last)
						state <= FINISH;
					else
						load_addr <= load_addr + 1'b1;
				end
				FINISH: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/prg_header.sv ====
`timescale 1ns/100ps
`default_nettype none

module prg_header import c64_loader_pkg::*; (
	input  wire         clk_sys,
	input  wire         reset_n,
	input  wire         accept_i,
	input  wire         is_prg_i,
	input  byte_t       dl_data_i,
	output c64_addr_t   prg_start_o,
	output c64_addr_t   prg_end_o,
	output logic        start_valid_o,
	output logic        prg_data_o
);

	logic [1:0] hdr_cnt;        // 2 once both address bytes are in

	always_ff @(posedge clk_sys) begin
		start_valid_o <= 1'b0;
		prg_data_o    <= 1'b0;
		if (!reset_n || !is_prg_i) begin
			hdr_cnt <= '0;
		end else if (accept_i) begin
			case (hdr_cnt)
				2'd0: begin
					prg_start_o[7:0] <= dl_data_i;     // Load address low byte
					hdr_cnt          <= 2'd1;
				end
				2'd1: begin
					prg_start_o[15:8] <= dl_data_i;
					prg_end_o         <= {dl_data_i, prg_start_o[7:0]};
					start_valid_o     <= 1'b1;
					hdr_cnt           <= 2'd2;
				end
				default: begin
					prg_end_o  <= prg_end_o + 1'b1;   // One past the last byte
					prg_data_o <= 1'b1;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/crt_parser.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "c64_loader_settings.svh"

module crt_parser import c64_loader_pkg::*; (
	input  wire         clk_sys,
	input  wire         reset_n,
	input  wire         accept_i,
	input  wire         is_crt_i,
	input  byte_t       dl_data_i,
	input  sdram_addr_t load_addr_i,
	output logic        crt_data_o,
	output logic        crt_align_o,
	output c64_addr_t   cart_id_o,
	output byte_t       cart_exrom_o,
	output byte_t       cart_game_o,
	output logic        bank_wr_o,
	output byte_t       bank_type_o,
	output c64_addr_t   bank_num_o,
	output c64_addr_t   bank_laddr_o,
	output c64_addr_t   bank_size_o,
	output sdram_addr_t bank_addr_o
);

	localparam logic [6:0] LAST_FILE_OFS = 7'(`CRT_CHIP_OFS - 1);
	localparam crt_len_t   HDR_LEN       = crt_len_t'(`CRT_CHIP_HDR_LEN);

	crt_state_t state;
	logic [6:0] file_ofs;
	logic [3:0] pkt_ofs;        // Byte inside a chip packet header
	crt_len_t   blk_len;
	crt_len_t   remain;

	always_ff @(posedge clk_sys) begin
		crt_data_o  <= 1'b0;
		crt_align_o <= 1'b0;
		bank_wr_o   <= 1'b0;
		if (!reset_n || !is_crt_i) begin
			state    <= FILE_HDR;
			file_ofs <= '0;
			pkt_ofs  <= '0;
		end else if (accept_i) begin
			case (state)
				// ============================================================
				// File header, 0x40 bytes
				// ============================================================
				FILE_HDR: begin
					file_ofs <= file_ofs + 1'b1;
					if (file_ofs == 7'(`CRT_ID_OFS))     cart_id_o[15:8] <= dl_data_i;
					if (file_ofs == 7'(`CRT_ID_OFS + 1)) cart_id_o[7:0]  <= dl_data_i;
					if (file_ofs == 7'(`CRT_EXROM_OFS))  cart_exrom_o    <= dl_data_i;
					if (file_ofs == 7'(`CRT_GAME_OFS))   cart_game_o     <= dl_data_i;
					if (file_ofs == LAST_FILE_OFS)
						state <= CHIP_HDR;
				end

				// ============================================================
				// Chip packet header, big endian fields
				// ============================================================
				CHIP_HDR: begin
					pkt_ofs <= pkt_ofs + 1'b1;     // Wraps to 0 after byte 15
					case (pkt_ofs)
						4'd0:  crt_align_o         <= 1'b1;    // Start on a fresh bank
						4'd4:  blk_len[31:24]      <= dl_data_i;
						4'd5:  blk_len[23:16]      <= dl_data_i;
						4'd6:  blk_len[15:8]       <= dl_data_i;
						4'd7:  blk_len[7:0]        <= dl_data_i;
						4'd9:  bank_type_o         <= dl_data_i;
						4'd10: bank_num_o[15:8]    <= dl_data_i;
						4'd11: bank_num_o[7:0]     <= dl_data_i;
						4'd12: bank_laddr_o[15:8]  <= dl_data_i;
						4'd13: bank_laddr_o[7:0]   <= dl_data_i;
						4'd14: bank_size_o[15:8]   <= dl_data_i;
						4'd15: begin
							bank_size_o[7:0] <= dl_data_i;
							bank_addr_o      <= load_addr_i;   // Already aligned
							bank_wr_o        <= 1'b1;
							remain           <= blk_len - HDR_LEN;
							if (blk_len != HDR_LEN)
								state <= CHIP_DATA;
						end
						default: ;
					endcase
				end

				CHIP_DATA: begin
					crt_data_o <= 1'b1;
					remain     <= remain - 1'b1;
					if (remain == crt_len_t'(1))
						state <= CHIP_HDR;            // Next packet follows
				end

				default: state <= FILE_HDR;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/basic_ptr_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module basic_ptr_gen import c64_loader_pkg::*; (
	input  byte_t       init_addr_i,
	input  c64_addr_t   prg_end_i,
	output logic        patch_o,
	output byte_t       patch_val_o
);

	// Zero page as a BASIC LOAD leaves it
	always_comb begin
		patch_o     = 1'b1;
		patch_val_o = 8'h00;
		case (init_addr_i)
			// Start of BASIC text, same as after reset
			8'h2B: patch_val_o = 8'h01;
			8'h2C: patch_val_o = 8'h08;

			// SAVE start left at zero
			8'hAC,
			8'hAD: patch_val_o = 8'h00;

			// VAR, ARY, STR and load end all point past the program
			8'h2D,
			8'h2F,
			8'h31,
			8'hAE: patch_val_o = prg_end_i[7:0];
			8'h2E,
			8'h30,
			8'h32,
			8'hAF: patch_val_o = prg_end_i[15:8];

			default: patch_o = 1'b0;   // Left untouched
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/mem_slot_writer.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_slot_writer import c64_loader_pkg::*; (
	input  wire         clk_sys,
	input  wire         reset_n,
	input  wire         io_slot_i,
	input  wire         wr_req_i,
	input  sdram_addr_t wr_addr_i,
	input  byte_t       wr_data_i,
	output logic        wr_busy_o,
	output logic        mem_we_o,
	output sdram_addr_t mem_addr_o,
	output byte_t       mem_data_o
);

	logic io_slot_q;
	logic slot_fall;
	logic pending;

	// Slot opens in the cycle after the falling edge is seen
	assign slot_fall = io_slot_q && !io_slot_i;
	assign wr_busy_o = pending;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			io_slot_q <= 1'b0;
			pending   <= 1'b0;
			mem_we_o  <= 1'b0;
		end else begin
			io_slot_q <= io_slot_i;
			mem_we_o  <= 1'b0;
			if (wr_req_i) begin
				pending <= 1'b1;
			end else if (pending && slot_fall) begin
				pending  <= 1'b0;
				mem_we_o <= 1'b1;     // Single cycle strobe
			end
		end
	end

	// Held steady until the next request
	always_ff @(posedge clk_sys) begin
		if (wr_req_i) begin
			mem_addr_o <= wr_addr_i;
			mem_data_o <= wr_data_i;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/c64_loader_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module c64_loader_top (
	input  wire                        clk_sys,
	input  wire                        reset_n,
	// Download stream
	input  wire                        dl_active_i,
	input  c64_loader_pkg::file_index_t dl_index_i,
	input  c64_loader_pkg::byte_t      dl_data_i,
	input  wire                        dl_valid_i,
	output logic                       dl_ready_o,
	// Memory side
	input  wire                        io_slot_i,
	output logic                       mem_we_o,
	output c64_loader_pkg::sdram_addr_t mem_addr_o,
	output c64_loader_pkg::byte_t      mem_data_o,
	// Cartridge side
	output c64_loader_pkg::c64_addr_t  cart_id_o,
	output c64_loader_pkg::byte_t      cart_exrom_o,
	output c64_loader_pkg::byte_t      cart_game_o,
	output logic                       cart_attached_o,
	output logic                       bank_wr_o,
	output c64_loader_pkg::byte_t      bank_type_o,
	output c64_loader_pkg::c64_addr_t  bank_num_o,
	output c64_loader_pkg::c64_addr_t  bank_laddr_o,
	output c64_loader_pkg::c64_addr_t  bank_size_o,
	output c64_loader_pkg::sdram_addr_t bank_addr_o,
	output logic                       inject_done_o
);

	logic                        accept;
	logic                        is_prg;
	logic                        is_crt;
	logic                        meminit;
	c64_loader_pkg::sdram_addr_t load_addr;
	logic                        wr_req;
	c64_loader_pkg::byte_t       wr_data;
	logic                        wr_busy;
	c64_loader_pkg::byte_t       init_addr;
	c64_loader_pkg::c64_addr_t   prg_start;
	c64_loader_pkg::c64_addr_t   prg_end;
	logic                        start_valid;
	logic                        prg_data;
	logic                        crt_data;
	logic                        crt_align;
	logic                        patch;
	c64_loader_pkg::byte_t       patch_val;

	load_ctrl u_ctrl (
		.clk_sys, .reset_n, .dl_active_i, .dl_index_i, .dl_data_i, .dl_valid_i,
		.prg_data_i(prg_data), .prg_start_i(prg_start), .start_valid_i(start_valid),
		.crt_data_i(crt_data), .crt_align_i(crt_align), .prg_end_i(prg_end),
		.patch_i(patch), .patch_val_i(patch_val), .wr_busy_i(wr_busy),
		.dl_ready_o, .accept_o(accept), .is_prg_o(is_prg), .is_crt_o(is_crt),
		.load_addr_o(load_addr), .wr_req_o(wr_req), .wr_data_o(wr_data),
		.cart_attached_o, .inject_done_o, .meminit_o(meminit), .init_addr_o(init_addr)
	);

	prg_header u_prg (
		.clk_sys, .reset_n, .accept_i(accept), .is_prg_i(is_prg), .dl_data_i,
		.prg_start_o(prg_start), .prg_end_o(prg_end),
		.start_valid_o(start_valid), .prg_data_o(prg_data)
	);

	crt_parser u_crt (
		.clk_sys, .reset_n, .accept_i(accept), .is_crt_i(is_crt), .dl_data_i,
		.load_addr_i(load_addr), .crt_data_o(crt_data), .crt_align_o(crt_align),
		.cart_id_o, .cart_exrom_o, .cart_game_o, .bank_wr_o, .bank_type_o,
		.bank_num_o, .bank_laddr_o, .bank_size_o, .bank_addr_o
	);

	basic_ptr_gen u_ptr (
		.init_addr_i(init_addr), .prg_end_i(prg_end),
		.patch_o(patch), .patch_val_o(patch_val)
	);

	mem_slot_writer u_wr (
		.clk_sys, .reset_n, .io_slot_i, .wr_req_i(wr_req),
		.wr_addr_i(load_addr), .wr_data_i(wr_data), .wr_busy_o(wr_busy),
		.mem_we_o, .mem_addr_o, .mem_data_o
	);

endmodule

`default_nettype wire

// ==== dv/c64_loader_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module c64_loader_assertions (
	input wire clk_sys,
	input wire reset_n,
	input wire io_slot_i,
	input wire mem_we_i,
	input wire dl_ready_i,
	input wire meminit_i
);

	// ============================================================
	// Memory slot protocol
	// ============================================================
	property we_single_cycle;
		@(posedge clk_sys) disable iff (!reset_n)
			mem_we_i |=> !mem_we_i;
	endproperty

	property we_after_slot_fall;    // Falling edge seen one cycle earlier
		@(posedge clk_sys) disable iff (!reset_n)
			mem_we_i |-> (!$past(io_slot_i) && $past(io_slot_i, 2));
	endproperty

	// Host held off during the zero page patch
	property no_ready_in_meminit;
		@(posedge clk_sys) disable iff (!reset_n)
			meminit_i |-> !dl_ready_i;
	endproperty

	a_we_single: assert property (we_single_cycle)
		else $error("mem_we_o high in two cycles in a row");
	a_we_slot: assert property (we_after_slot_fall)
		else $error("mem_we_o high outside an open slot");
	a_ready_meminit: assert property (no_ready_in_meminit)
		else $error("dl_ready_o high during meminit");

endmodule

bind c64_loader_top c64_loader_assertions u_assert (
	.clk_sys, .reset_n, .io_slot_i, .mem_we_i(mem_we_o),
	.dl_ready_i(dl_ready_o), .meminit_i(meminit)
);

`default_nettype wire

// ==== dv/c64_loader_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "c64_loader_settings.svh"

module c64_loader_tb import c64_loader_pkg::*; ();

	localparam int WAIT_LIMIT = 2000;    // Cycles per wait before giving up
	localparam int NUM_TESTS  = 4;

	typedef struct {
		logic        is_crt;
		c64_addr_t   addr;       // PRG load address or CRT bank load address
		int          len_a;      // PRG payload or first packet data length
		int          len_b;      // Second packet data length
		logic        gaps;       // Random idle cycles between bytes
		sdram_addr_t exp_a;      // PRG end address or first bank address
		sdram_addr_t exp_b;      // Second bank address
	} test_t;

	logic        clk_sys = 1'b0;
	logic        reset_n;
	logic        dl_active;
	file_index_t dl_index;
	byte_t       dl_data;
	logic        dl_valid;
	logic        dl_ready;
	logic        io_slot;
	logic        mem_we;
	sdram_addr_t mem_addr;
	byte_t       mem_data;
	c64_addr_t   cart_id;
	byte_t       cart_exrom;
	byte_t       cart_game;
	logic        cart_attached;
	logic        bank_wr;
	byte_t       bank_type;
	c64_addr_t   bank_num;
	c64_addr_t   bank_laddr;
	c64_addr_t   bank_size;
	sdram_addr_t bank_addr;
	logic        inject_done;

	test_t       tests [NUM_TESTS];
	byte_t       mem_model [sdram_addr_t];
	int          writes_total;
	int          writes_zp;
	int          done_pulses;
	sdram_addr_t bank_addr_q[$];
	c64_addr_t   bank_num_q[$];
	c64_addr_t   bank_laddr_q[$];
	c64_addr_t   bank_size_q[$];
	byte_t       bank_type_q[$];
	byte_t       file_q[$];
	sdram_addr_t exp_addr_q[$];
	byte_t       exp_data_q[$];
	int          errors;
	int          checks;
	int          failed_tests;
	bit          timed_out;
	int          slot_phase;

	c64_loader_top dut (
		.clk_sys, .reset_n,
		.dl_active_i(dl_active), .dl_index_i(dl_index), .dl_data_i(dl_data),
		.dl_valid_i(dl_valid), .dl_ready_o(dl_ready),
		.io_slot_i(io_slot), .mem_we_o(mem_we), .mem_addr_o(mem_addr), .mem_data_o(mem_data),
		.cart_id_o(cart_id), .cart_exrom_o(cart_exrom), .cart_game_o(cart_game),
		.cart_attached_o(cart_attached), .bank_wr_o(bank_wr), .bank_type_o(bank_type),
		.bank_num_o(bank_num), .bank_laddr_o(bank_laddr), .bank_size_o(bank_size),
		.bank_addr_o(bank_addr), .inject_done_o(inject_done)
	);

	always #4 clk_sys = ~clk_sys;

	// Host slot, falls once every 6 cycles
	always @(posedge clk_sys) begin
		#1;
		slot_phase = (slot_phase + 1) % 6;
		io_slot    = (slot_phase < 3);
	end

	// ============================================================
	// Memory, bank and done monitors
	// ============================================================
	always @(negedge clk_sys) begin
		if (mem_we) begin
			mem_model[mem_addr] = mem_data;
			writes_total++;
			if (mem_addr < sdram_addr_t'('h100))
				writes_zp++;
		end
		if (inject_done)
			done_pulses++;
		if (bank_wr) begin
			bank_addr_q.push_back(bank_addr);
			bank_num_q.push_back(bank_num);
			bank_laddr_q.push_back(bank_laddr);
			bank_size_q.push_back(bank_size);
			bank_type_q.push_back(bank_type);
		end
	end

	task automatic check(input bit ok, input string what);
		checks++;
		assert (ok) else begin
			$display("Error at %0t ns: %s", $time, what);
			errors++;
		end
	endtask

	task automatic next_edge();
		@(posedge clk_sys);
		#1;
	endtask

	// Zero page contents after a BASIC LOAD, {patched, value}
	function automatic logic [8:0] zp_expected(input int a, input c64_addr_t end_addr);
		case (a)
			'h2B: return {1'b1, 8'h01};
			'h2C: return {1'b1, 8'h08};
			'hAC, 'hAD: return {1'b1, 8'h00};
			'h2D, 'h2F, 'h31, 'hAE: return {1'b1, end_addr[7:0]};
			'h2E, 'h30, 'h32, 'hAF: return {1'b1, end_addr[15:8]};
			default: return 9'h000;
		endcase
	endfunction

	task automatic send_file(input file_index_t idx, input bit gaps);
		int  tries;
		int  gap;
		bit  taken;
		dl_active = 1'b1;
		dl_index  = idx;
		next_edge();
		for (int i = 0; i < file_q.size() && !timed_out; i++) begin
			gap = gaps ? int'($urandom % 4) : 0;
			repeat (gap) next_edge();
			dl_data  = file_q[i];
			dl_valid = 1'b1;
			taken    = 1'b0;
			tries    = 0;
			while (!taken && tries < WAIT_LIMIT) begin
				@(negedge clk_sys);
				taken = dl_ready;          // Ready is stable until the next edge
				next_edge();
				tries++;
			end
			if (!taken) begin
				$display("Timeout: byte %0d of the file was never accepted", i);
				timed_out = 1'b1;
			end
			dl_valid = 1'b0;
		end
	endtask

	task automatic wait_writes(input int n);
		int tries;
		tries = 0;
		while (writes_total < n && tries < WAIT_LIMIT) begin
			@(negedge clk_sys);
			tries++;
		end
		if (writes_total < n) begin
			$display("Timeout: only %0d of %0d memory writes were seen", writes_total, n);
			timed_out = 1'b1;
		end
		next_edge();
	endtask

	task automatic wait_inject_done();
		int tries;
		tries = 0;
		while (done_pulses == 0 && tries < WAIT_LIMIT) begin
			@(negedge clk_sys);
			tries++;
		end
		if (done_pulses == 0) begin
			$display("Timeout: the zero page patch never finished");
			timed_out = 1'b1;
		end
		next_edge();
	endtask

	task automatic wait_cart_attached();
		int tries;
		tries = 0;
		while (!cart_attached && tries < WAIT_LIMIT) begin
			@(negedge clk_sys);
			tries++;
		end
		if (!cart_attached) begin
			$display("Timeout: the cartridge was never flagged as attached");
			timed_out = 1'b1;
		end
		next_edge();
	endtask

	// ============================================================
	// File builders
	// ============================================================
	task automatic build_prg(input test_t t);
		byte_t b;
		file_q.push_back(t.addr[7:0]);
		file_q.push_back(t.addr[15:8]);
		for (int i = 0; i < t.len_a; i++) begin
			b = byte_t'($urandom);
			file_q.push_back(b);
			exp_addr_q.push_back(sdram_addr_t'(t.addr) + sdram_addr_t'(i));
			exp_data_q.push_back(b);
		end
	endtask

	task automatic add_packet(input int num, input c64_addr_t laddr, input int len,
			input byte_t chip_type, input sdram_addr_t base);
		crt_len_t total;
		byte_t    b;
		total = crt_len_t'(len + `CRT_CHIP_HDR_LEN);
		file_q.push_back(8'h43);    // "CHIP"
		file_q.push_back(8'h48);
		file_q.push_back(8'h49);
		file_q.push_back(8'h50);
		for (int k = 3; k >= 0; k--)
			file_q.push_back(total[k*8 +: 8]);
		file_q.push_back(8'h00);
		file_q.push_back(chip_type);    // Bank type, low byte
		file_q.push_back(byte_t'(num >> 8));
		file_q.push_back(byte_t'(num));
		file_q.push_back(laddr[15:8]);
		file_q.push_back(laddr[7:0]);
		file_q.push_back(byte_t'(len >> 8));
		file_q.push_back(byte_t'(len));
		for (int i = 0; i < len; i++) begin
			b = byte_t'($urandom);
			file_q.push_back(b);
			exp_addr_q.push_back(base + sdram_addr_t'(i));
			exp_data_q.push_back(b);
		end
	endtask

	task automatic check_payload();
		byte_t got;
		foreach (exp_addr_q[i]) begin
			got = mem_model.exists(exp_addr_q[i]) ? mem_model[exp_addr_q[i]] : 8'hxx;
			check(got === exp_data_q[i], $sformatf("memory at %h holds %h, expected %h",
				exp_addr_q[i], got, exp_data_q[i]));
		end
	endtask

	task automatic run_prg(input test_t t);
		logic [8:0] ev;
		int         zp_count;
		byte_t      got;
		build_prg(t);
		send_file(`PRG_INDEX, t.gaps);
		wait_writes(t.len_a);
		dl_active = 1'b0;
		wait_inject_done();
		repeat (4) next_edge();
		check_payload();
		zp_count = 0;
		for (int a = 0; a < 'h100; a++) begin
			ev = zp_expected(a, t.exp_a[15:0]);
			if (ev[8]) begin
				zp_count++;
				got = mem_model.exists(sdram_addr_t'(a)) ? mem_model[sdram_addr_t'(a)] : 8'hxx;
				check(got === ev[7:0], $sformatf("zero page %h holds %h, expected %h",
					a, got, ev[7:0]));
			end
		end
		check(writes_zp == zp_count, $sformatf("%0d zero page writes, expected %0d",
			writes_zp, zp_count));
		check(writes_total == t.len_a + zp_count, $sformatf("%0d writes in total",
			writes_total));
		check(done_pulses == 1, $sformatf("inject done pulsed %0d times", done_pulses));
	endtask

	task automatic run_crt(input test_t t);
		c64_addr_t id;
		byte_t     exrom;
		byte_t     game;
		id    = c64_addr_t'($urandom);
		exrom = byte_t'($urandom);
		game  = byte_t'($urandom);
		for (int i = 0; i < `CRT_CHIP_OFS; i++)
			file_q.push_back(byte_t'($urandom));
		file_q[`CRT_ID_OFS]     = id[15:8];
		file_q[`CRT_ID_OFS + 1] = id[7:0];
		file_q[`CRT_EXROM_OFS]  = exrom;
		file_q[`CRT_GAME_OFS]   = game;
		add_packet(0, t.addr, t.len_a, 8'h02, t.exp_a);    // Flash bank
		add_packet(1, t.addr, t.len_b, 8'h00, t.exp_b);    // ROM bank
		send_file(`CRT_INDEX, t.gaps);
		wait_writes(t.len_a + t.len_b);
		dl_active = 1'b0;
		wait_cart_attached();
		check(cart_id == id, $sformatf("cartridge id %h, expected %h", cart_id, id));
		check(cart_exrom == exrom, $sformatf("EXROM %h, expected %h", cart_exrom, exrom));
		check(cart_game == game, $sformatf("GAME %h, expected %h", cart_game, game));
		check(bank_addr_q.size() == 2, $sformatf("%0d bank records", bank_addr_q.size()));
		if (bank_addr_q.size() == 2) begin
			check(bank_addr_q[0] == t.exp_a, $sformatf("bank 0 at %h", bank_addr_q[0]));
			check(bank_addr_q[1] == t.exp_b, $sformatf("bank 1 at %h", bank_addr_q[1]));
			check(bank_num_q[0] == 0 && bank_num_q[1] == 1, "bank numbers differ");
			check(bank_laddr_q[0] == t.addr && bank_laddr_q[1] == t.addr,
				"bank load addresses differ");
			check(bank_size_q[0] == c64_addr_t'(t.len_a) && bank_size_q[1] == c64_addr_t'(t.len_b),
				"bank sizes differ");
			check(bank_type_q[0] == 8'h02 && bank_type_q[1] == 8'h00, "bank types differ");
		end
		check_payload();
		check(writes_total == t.len_a + t.len_b, $sformatf("%0d writes in total", writes_total));
		check(cart_attached === 1'b1, "cartridge not attached");
	endtask

	// ============================================================
	// Main sequence
	// ============================================================
	initial begin
		int seed_val;
		int errors_before;
		seed_val   = $urandom(32'hf7f4_00a0);
		reset_n    = 1'b0;
		dl_active  = 1'b0;
		dl_index   = '0;
		dl_data    = '0;
		dl_valid   = 1'b0;
		io_slot    = 1'b1;
		slot_phase = 0;
		errors     = 0;
		checks     = 0;
		failed_tests = 0;
		timed_out  = 1'b0;

		tests[0] = '{1'b0, 16'h0801, 40, 0, 1'b0, 25'h000829, 25'h0};
		tests[1] = '{1'b0, 16'hC000, 25, 0, 1'b1, 25'h00C019, 25'h0};
		tests[2] = '{1'b1, 16'h8000, 37, 20, 1'b0, 25'h100000, 25'h102000};
		tests[3] = '{1'b1, 16'hA000, 8192, 5, 1'b1, 25'h100000, 25'h102000};   // Already aligned

		repeat (10) @(posedge clk_sys);
		#1 reset_n = 1'b1;
		@(negedge clk_sys);
		errors_before = errors;
		check(!dl_ready && !mem_we && !bank_wr && !inject_done && !cart_attached,
			"outputs not idle after reset");
		$display("Test reset: %s", (errors == errors_before) ? "pass" : "FAIL");
		if (errors != errors_before)
			failed_tests++;

		for (int n = 0; n < NUM_TESTS && !timed_out; n++) begin
			mem_model.delete();
			file_q.delete();
			exp_addr_q.delete();
			exp_data_q.delete();
			bank_addr_q.delete();
			bank_num_q.delete();
			bank_laddr_q.delete();
			bank_size_q.delete();
			bank_type_q.delete();
			writes_total  = 0;
			writes_zp     = 0;
			done_pulses   = 0;
			errors_before = errors;
			repeat (3) next_edge();
			if (tests[n].is_crt)
				run_crt(tests[n]);
			else
				run_prg(tests[n]);
			if (errors != errors_before || timed_out)
				failed_tests++;
			$display("Test %0d %s: %s", n, tests[n].is_crt ? "CRT" : "PRG",
				(errors == errors_before && !timed_out) ? "pass" : "FAIL");
		end

		$display("Tests failed %0d, checks %0d, errors %0d", failed_tests, checks, errors);
		if (errors == 0 && failed_tests == 0 && !timed_out)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+rtl
rtl/c64_loader_pkg.sv
rtl/load_ctrl.sv
rtl/prg_header.sv
rtl/crt_parser.sv
rtl/basic_ptr_gen.sv
rtl/mem_slot_writer.sv
rtl/c64_loader_top.sv
dv/c64_loader_assertions.sv
dv/c64_loader_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the loader testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module c64_loader_tb -f filelist.f -o sim_c64_loader
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/sim_c64_loader 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Verification passed"; then
	exit 0
fi
exit 1
